// ==== design/router_pkg.sv ====
// ********************
// shared constants and types of the
// 16-port serial packet router
// ********************
package router_pkg;

	// number of input ports, and of output ports
	localparam int NUM_PORTS = 16;

	// header is the output address, lsb first, then a marker bit of 1
	localparam int ADDR_BITS = $clog2(NUM_PORTS);
	localparam int HEADER_BITS = ADDR_BITS + 1;

	// header bit counter runs from 0 up to HEADER_BITS
	localparam int HDR_CNT_BITS = $clog2(HEADER_BITS + 1);

	typedef logic [ADDR_BITS-1:0] port_idx_t;
	typedef logic [NUM_PORTS-1:0] port_mask_t;
	typedef logic [HDR_CNT_BITS-1:0] hdr_cnt_t;

	// request mask of every input, indexed [input][output]
	typedef port_mask_t [NUM_PORTS-1:0] req_matrix_t;

	// granted input of every output
	typedef port_idx_t [NUM_PORTS-1:0] port_sel_t;

endpackage

// ==== design/header_capture.sv ====
// ********************
// per-input frame tracking and header capture,
// output request, busy_n and payload accept
// ********************
module header_capture (
	input  logic clock,
	input  logic reset,
	input  logic frame_n,
	input  logic valid_n,
	input  logic din,
	input  logic in_granted,
	output router_pkg::port_mask_t request,
	output logic in_data,
	output logic in_fwd,
	output logic in_frame,
	output logic busy_n
);

	// input register stage
	logic frame1_n;
	logic din1;
	logic take1;

	// address bits gathered so far, a0 ends up in bit 0
	router_pkg::port_idx_t addr_sr;
	router_pkg::hdr_cnt_t hdr_cnt;

	logic frame_start;
	logic frame_end;
	logic addr_phase;
	logic marker_phase;
	logic hdr_done;

	// registered frame_n low with no frame open marks E1 of a new frame
	assign frame_start = !in_frame && !frame1_n;
	assign frame_end = in_frame && frame1_n;

	assign addr_phase = in_frame &&
		(hdr_cnt < router_pkg::hdr_cnt_t'(router_pkg::ADDR_BITS));
	assign marker_phase = in_frame &&
		(hdr_cnt == router_pkg::hdr_cnt_t'(router_pkg::ADDR_BITS));
	assign hdr_done = (hdr_cnt == router_pkg::hdr_cnt_t'(router_pkg::HEADER_BITS));

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			frame1_n <= 1'b1;
			take1 <= 1'b0;
			in_frame <= 1'b0;
			hdr_cnt <= '0;
			request <= '0;
			busy_n <= 1'b1;
			in_fwd <= 1'b0;
		end
		else
		begin
			frame1_n <= frame_n;
			// offer taken only with busy_n high and frame_n still low
			take1 <= !valid_n && !frame_n && busy_n;
			in_fwd <= take1 && in_frame && hdr_done;

			if (frame_end)
			begin
				in_frame <= 1'b0;
				hdr_cnt <= '0;
				request <= '0;
				busy_n <= 1'b1;
			end
			else if (frame_start)
			begin
				// a0 shifts in on this edge
				in_frame <= 1'b1;
				hdr_cnt <= router_pkg::hdr_cnt_t'(1);
				busy_n <= 1'b0;
			end
			else
			begin
				if (addr_phase)
				begin
					hdr_cnt <= hdr_cnt + 1'b1;
				end
				else if (marker_phase)
				begin
					hdr_cnt <= router_pkg::hdr_cnt_t'(router_pkg::HEADER_BITS);
					// zero marker, frame is ignored until it ends
					if (din1)
						request <= router_pkg::port_mask_t'(1) << addr_sr;
				end

				// connection made, payload may flow until the frame ends
				if (in_frame && in_granted)
					busy_n <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		din1 <= din;
		in_data <= din1;
		if (frame_start || addr_phase)
			addr_sr <= {din1, addr_sr[router_pkg::ADDR_BITS-1:1]};
	end

	// one-hot request, alive only inside a frame
	assert property (@(posedge clock) disable iff (!reset)
		$onehot0(request) && (in_frame || request == '0));

endmodule

// ==== design/switch_arbiter.sv ====
// ********************
// round-robin grant and hold per output,
// grant status per input
// ********************
module switch_arbiter (
	input  logic clock,
	input  logic reset,
	input  router_pkg::req_matrix_t requests,
	output router_pkg::port_mask_t in_granted,
	output router_pkg::port_mask_t out_active,
	output router_pkg::port_sel_t out_sel
);

	// search start per output, one past the last grantee
	router_pkg::port_sel_t rr_ptr;

	// first requester at or after the pointer, per output
	router_pkg::port_sel_t pick;
	router_pkg::port_mask_t any_req;

	// grant_matrix[i][o] set while output o is held by input i
	router_pkg::req_matrix_t grant_matrix;

	// scanned from the far end so the nearest requester wins
	function automatic router_pkg::port_idx_t rr_pick(
		input router_pkg::port_mask_t column,
		input router_pkg::port_idx_t ptr
	);
		router_pkg::port_idx_t idx;
		router_pkg::port_idx_t best;
		best = ptr;
		for (int k = router_pkg::NUM_PORTS - 1; k >= 0; k--)
		begin
			idx = ptr + router_pkg::port_idx_t'(k);
			if (column[idx])
				best = idx;
		end
		return best;
	endfunction

	for (genvar o = 0; o < router_pkg::NUM_PORTS; o++)
	begin : g_out
		router_pkg::port_mask_t column;

		for (genvar i = 0; i < router_pkg::NUM_PORTS; i++)
		begin : g_in
			assign column[i] = requests[i][o];
			assign grant_matrix[i][o] = out_active[o] &&
				(out_sel[o] == router_pkg::port_idx_t'(i));

			// a grant outlives its request by the release edge at most
			assert property (@(posedge clock) disable iff (!reset)
				grant_matrix[i][o] |-> requests[i][o] || $past(requests[i][o]));
		end

		assign any_req[o] = |column;
		assign pick[o] = rr_pick(column, rr_ptr[o]);
	end

	for (genvar i = 0; i < router_pkg::NUM_PORTS; i++)
	begin : g_status
		assign in_granted[i] = |grant_matrix[i];

		// never two outputs on one input
		assert property (@(posedge clock) disable iff (!reset)
			$onehot0(grant_matrix[i]));
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			out_active <= '0;
			out_sel <= '0;
			rr_ptr <= '0;
		end
		else
		begin
			for (int o = 0; o < router_pkg::NUM_PORTS; o++)
			begin
				if (out_active[o])
				begin
					// held until the grantee's frame is over
					if (!requests[out_sel[o]][o])
					begin
						out_active[o] <= 1'b0;
						rr_ptr[o] <= out_sel[o] + 1'b1;
					end
				end
				else if (any_req[o])
				begin
					out_active[o] <= 1'b1;
					out_sel[o] <= pick[o];
				end
			end
		end
	end

endmodule

// ==== design/crossbar.sv ====
// ********************
// registered per-output select of frame,
// valid and data from the granted input
// ********************
module crossbar (
	input  logic clock,
	input  logic reset,
	input  router_pkg::port_mask_t in_data,
	input  router_pkg::port_mask_t in_fwd,
	input  router_pkg::port_mask_t in_frame,
	input  router_pkg::port_mask_t out_active,
	input  router_pkg::port_sel_t out_sel,
	output router_pkg::port_mask_t dout,
	output router_pkg::port_mask_t valido_n,
	output router_pkg::port_mask_t frameo_n
);

	// granted input's signals seen at each output
	router_pkg::port_mask_t sel_data;
	router_pkg::port_mask_t sel_fwd;
	router_pkg::port_mask_t sel_frame;

	always_comb
	begin
		for (int o = 0; o < router_pkg::NUM_PORTS; o++)
		begin
			sel_data[o] = in_data[out_sel[o]];
			sel_fwd[o] = in_fwd[out_sel[o]];
			sel_frame[o] = in_frame[out_sel[o]];
		end
	end

	// output stage, an idle output sits at frame and valid high, data 0
	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			dout <= '0;
			valido_n <= '1;
			frameo_n <= '1;
		end
		else
		begin
			frameo_n <= ~(out_active & sel_frame);
			valido_n <= ~(out_active & sel_fwd);
			dout <= out_active & sel_fwd & sel_data;
		end
	end

	// every forwarded bit falls inside its output frame window
	assert property (@(posedge clock) disable iff (!reset)
		(~valido_n & frameo_n) == '0);

endmodule

// ==== design/router_top.sv ====
// ********************
// router top level, sixteen header captures,
// switch arbiter and crossbar
// ********************
module router_top (
	input  logic clock,
	input  logic reset,
	input  router_pkg::port_mask_t frame_n,
	input  router_pkg::port_mask_t valid_n,
	input  router_pkg::port_mask_t din,
	output wire router_pkg::port_mask_t busy_n,
	output wire router_pkg::port_mask_t dout,
	output wire router_pkg::port_mask_t valido_n,
	output wire router_pkg::port_mask_t frameo_n
);

	// request mask of every input toward the outputs
	wire router_pkg::req_matrix_t requests;

	// per-input status and registered payload
	wire router_pkg::port_mask_t in_granted;
	wire router_pkg::port_mask_t in_data;
	wire router_pkg::port_mask_t in_fwd;
	wire router_pkg::port_mask_t in_frame;

	// per-output connection state
	wire router_pkg::port_mask_t out_active;
	wire router_pkg::port_sel_t out_sel;

	for (genvar i = 0; i < router_pkg::NUM_PORTS; i++)
	begin : g_port
		header_capture i_capture (
			.clock(clock),
			.reset(reset),
			.frame_n(frame_n[i]),
			.valid_n(valid_n[i]),
			.din(din[i]),
			.in_granted(in_granted[i]),
			.request(requests[i]),
			.in_data(in_data[i]),
			.in_fwd(in_fwd[i]),
			.in_frame(in_frame[i]),
			.busy_n(busy_n[i])
		);
	end

	switch_arbiter i_arbiter (
		.clock(clock),
		.reset(reset),
		.requests(requests),
		.in_granted(in_granted),
		.out_active(out_active),
		.out_sel(out_sel)
	);

	// two cycles from an accepted bit to dout
	crossbar i_crossbar (
		.clock(clock),
		.reset(reset),
		.in_data(in_data),
		.in_fwd(in_fwd),
		.in_frame(in_frame),
		.out_active(out_active),
		.out_sel(out_sel),
		.dout(dout),
		.valido_n(valido_n),
		.frameo_n(frameo_n)
	);

endmodule

// ==== include/router_tb_model.svh ====
// ********************
// testbench packet records, reference routing
// function and expected-queue helpers
// ********************
`ifndef ROUTER_TB_MODEL_SVH
`define ROUTER_TB_MODEL_SVH

// one record per packet id, in the order the packets were made
int pkt_count = 0;
int pkt_src[NUM_PACKETS];
router_pkg::port_idx_t pkt_addr[NUM_PACKETS];
bit pkt_marker[NUM_PACKETS];
// payload bits the router accepted, in order
bit pkt_payload[NUM_PACKETS][$];

// packet ids still expected per output, oldest first
int exp_q[router_pkg::NUM_PORTS][$];

// header in send order, a0 in bit 0 and the marker last
function automatic bit [router_pkg::HEADER_BITS-1:0] packet_header(int id);
	return {pkt_marker[id], pkt_addr[id]};
endfunction

// output port a header routes to, -1 when the header is dropped
function automatic int expected_output(bit [router_pkg::HEADER_BITS-1:0] hdr);
	if (hdr[router_pkg::HEADER_BITS-1] == 1'b0)
		return -1;
	return int'(hdr[router_pkg::ADDR_BITS-1:0]);
endfunction

// fresh packet record, returns its id
function automatic int new_packet(int src, int addr, bit marker);
	int id;
	id = pkt_count;
	pkt_count++;
	pkt_src[id] = src;
	pkt_addr[id] = router_pkg::port_idx_t'(addr);
	pkt_marker[id] = marker;
	pkt_payload[id].delete();
	return id;
endfunction

// file a packet on the queue of the output it should leave from
function automatic void expect_packet(int id);
	int port;
	port = expected_output(packet_header(id));
	if (port >= 0)
		exp_q[port].push_back(id);
endfunction

// oldest packet still expected on a port, -1 when none is left
function automatic int next_expected(int port);
	if (exp_q[port].size() == 0)
		return -1;
	return exp_q[port].pop_front();
endfunction

// packets still waiting over all outputs
function automatic int expected_left();
	int total;
	total = 0;
	foreach (exp_q[p])
		total += exp_q[p].size();
	return total;
endfunction

// first bit where a received frame differs from its packet, -1 when equal
function automatic int payload_mismatch(int id, bit got[$]);
	int len;
	len = (pkt_payload[id].size() < got.size()) ? pkt_payload[id].size() : got.size();
	for (int k = 0; k < len; k++)
	begin
		if (pkt_payload[id][k] != got[k])
			return k;
	end
	if (pkt_payload[id].size() != got.size())
		return len;
	return -1;
endfunction

`endif

// ==== tests/router_tb.sv ====
// ********************
// router testbench with stimulus, output
// monitors, frame compare and watchdog
// ********************
module router_tb;

	// contention, single, parallel, back-pressure and malformed runs
	localparam int NUM_PACKETS = 66;
	localparam int MAX_PKT_LEN = 48;
	localparam int WATCHDOG_TIME =
		NUM_PACKETS * (MAX_PKT_LEN + router_pkg::NUM_PORTS * MAX_PKT_LEN) * 4;
	localparam int N = router_pkg::NUM_PORTS;

	logic clock;
	logic reset;
	router_pkg::port_mask_t frame_n;
	router_pkg::port_mask_t valid_n;
	router_pkg::port_mask_t din;
	router_pkg::port_mask_t busy_n;
	router_pkg::port_mask_t dout;
	router_pkg::port_mask_t valido_n;
	router_pkg::port_mask_t frameo_n;

	int errors;
	int frames_checked;
	int cycle = 0;

	// accept cycles per input
	int accept_q[router_pkg::NUM_PORTS][$];

	// last finished frame per output, and the outputs waiting for compare
	bit rx_bits[router_pkg::NUM_PORTS][$];
	int rx_cycles[router_pkg::NUM_PORTS][$];
	int rx_port_q[$];

`include "router_tb_model.svh"

	router_top i_dut (
		.clock(clock),
		.reset(reset),
		.frame_n(frame_n),
		.valid_n(valid_n),
		.din(din),
		.busy_n(busy_n),
		.dout(dout),
		.valido_n(valido_n),
		.frameo_n(frameo_n)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
		cycle <= cycle + 1;

	// new packet, filed where the reference says it leaves
	function automatic int queue_packet(int src, int addr, bit marker);
		int id;
		id = new_packet(src, addr, marker);
		expect_packet(id);
		return id;
	endfunction

	// wrong value seen on a DUT output
	task automatic report_mismatch(string name, logic [31:0] expected,
		logic [31:0] actual);
		errors++;
		$display("[FAIL] %0t %s: expected %0d, actual %0d", $time, name, expected, actual);
	endtask

	// header, then offers until len bits are taken
	// a dropped header only gets len offers
	task automatic send_frame(int id, int len, bit gappy);
		bit [router_pkg::HEADER_BITS-1:0] hdr;
		int p;
		int taken;
		int offers;
		bit b;
		hdr = packet_header(id);
		p = pkt_src[id];
		taken = 0;
		offers = 0;
		for (int k = 0; k < router_pkg::HEADER_BITS; k++)
		begin
			@(negedge clock);
			frame_n[p] = 1'b0;
			valid_n[p] = 1'b1;
			din[p] = hdr[k];
		end
		b = 1'($urandom);
		while (pkt_marker[id] ? (taken < len) : (offers < len))
		begin
			@(negedge clock);
			if (gappy && ($urandom % 4 == 0))
			begin
				valid_n[p] = 1'b1;
				din[p] = 1'($urandom);
			end
			else
			begin
				valid_n[p] = 1'b0;
				din[p] = b;
				offers++;
				// busy_n now is the value the next rising edge samples
				if (busy_n[p])
				begin
					pkt_payload[id].push_back(b);
					accept_q[p].push_back(cycle + 1);
					taken++;
					b = 1'($urandom);
				end
			end
		end
		@(negedge clock);
		frame_n[p] = 1'b1;
		valid_n[p] = 1'b1;
		din[p] = 1'b0;
	endtask

	// one source walking its own lane of outputs, lane + 4k
	task automatic stream_packets(int src, int lane);
		int id;
		for (int k = 0; k < 4; k++)
		begin
			id = queue_packet(src, lane + 4 * k, 1'b1);
			send_frame(id, $urandom_range(24, 4), 1'b1);
			repeat ($urandom_range(4, 0)) @(negedge clock);
		end
	endtask

	initial
	begin : main
		int ids[router_pkg::NUM_PORTS];
		int lens[router_pkg::NUM_PORTS];
		int src;
		int target;
		void'($urandom(32'h89b2f502));
		clock = 1'b0;
		reset = 1'b0;
		frame_n = '1;
		valid_n = '1;
		din = '0;
		errors = 0;
		frames_checked = 0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;
		@(negedge clock);
		if (busy_n !== '1)
			report_mismatch("busy_n after reset", 32'hffff, busy_n);
		if (frameo_n !== '1)
			report_mismatch("frameo_n after reset", 32'hffff, frameo_n);
		if (valido_n !== '1)
			report_mismatch("valido_n after reset", 32'hffff, valido_n);
		if (dout !== '0)
			report_mismatch("dout after reset", 32'h0, dout);

		// all inputs at once toward one output, round-robin from pointer 0
		target = $urandom_range(N - 1, 0);
		for (int i = 0; i < N; i++)
		begin
			ids[i] = queue_packet(i, target, 1'b1);
			lens[i] = 4 + i;
		end
		for (int i = 0; i < N; i++)
		begin
			automatic int s = i;
			fork
				send_frame(ids[s], lens[s], 1'b0);
			join_none
		end
		wait fork;
		repeat (6) @(negedge clock);

		// one packet per address, one at a time
		for (int a = 0; a < N; a++)
		begin
			src = $urandom_range(N - 1, 0);
			ids[0] = queue_packet(src, a, 1'b1);
			send_frame(ids[0], $urandom_range(24, 4), 1'b0);
			repeat (4) @(negedge clock);
		end

		// every input to a different output
		for (int i = 0; i < N; i++)
		begin
			ids[i] = queue_packet(i, (i * 5 + 3) % N, 1'b1);
			lens[i] = $urandom_range(24, 4);
		end
		for (int i = 0; i < N; i++)
		begin
			automatic int s = i;
			fork
				send_frame(ids[s], lens[s], 1'b0);
			join_none
		end
		wait fork;
		repeat (6) @(negedge clock);

		// valid_n gaps and offers while busy_n is low
		for (int l = 0; l < 4; l++)
		begin
			automatic int lane = l;
			automatic int s = 4 * l + $urandom_range(3, 0);
			fork
				stream_packets(s, lane);
			join_none
		end
		wait fork;
		repeat (6) @(negedge clock);

		// zero marker, then a good packet from the same input
		src = $urandom_range(N - 1, 0);
		ids[0] = queue_packet(src, 9, 1'b0);
		send_frame(ids[0], 8, 1'b0);
		repeat (2) @(negedge clock);
		if (busy_n[src] !== 1'b1)
			report_mismatch($sformatf("busy_n[%0d] after dropped frame", src), 1, busy_n[src]);
		ids[1] = queue_packet(src, 9, 1'b1);
		send_frame(ids[1], 12, 1'b0);

		while (expected_left() != 0 || rx_port_q.size() != 0)
			@(negedge clock);
		repeat (10) @(negedge clock);
		if (frameo_n !== '1)
		begin
			errors++;
			$display("%0t: an output frame is still open after the last packet", $time);
		end
		$display("errors: %0d, frames checked: %0d", errors, frames_checked);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// collect each output frame, bits with valido_n low while frameo_n is low
	for (genvar o = 0; o < router_pkg::NUM_PORTS; o++)
	begin : g_mon
		initial
		begin
			bit bits[$];
			int cycles[$];
			bit open;
			open = 1'b0;
			@(posedge reset);
			forever
			begin
				@(negedge clock);
				if (!frameo_n[o])
				begin
					if (!open)
					begin
						open = 1'b1;
						bits.delete();
						cycles.delete();
					end
					if (!valido_n[o])
					begin
						bits.push_back(dout[o]);
						cycles.push_back(cycle);
					end
				end
				else
				begin
					if (!valido_n[o])
					begin
						errors++;
						$display("%0t: valido_n[%0d] went low outside a frame", $time, o);
					end
					if (open)
					begin
						open = 1'b0;
						rx_bits[o] = bits;
						rx_cycles[o] = cycles;
						rx_port_q.push_back(o);
					end
				end
			end
		end
	end

	initial
	begin : compare
		int port;
		int id;
		int at;
		int acc;
		bit late;
		bit got[$];
		int got_cyc[$];
		forever
		begin
			@(posedge clock);
			while (rx_port_q.size() > 0)
			begin
				port = rx_port_q.pop_front();
				got = rx_bits[port];
				got_cyc = rx_cycles[port];
				id = next_expected(port);
				frames_checked++;
				if (id < 0)
				begin
					errors++;
					$display("%0t: output %0d carried a frame no packet was routed to",
						$time, port);
				end
				else
				begin
					at = payload_mismatch(id, got);
					if (at >= 0 && at < got.size() && at < pkt_payload[id].size())
						report_mismatch($sformatf("dout[%0d] bit %0d from input %0d",
							port, at, pkt_src[id]), pkt_payload[id][at], got[at]);
					else if (at >= 0)
						report_mismatch($sformatf("dout[%0d] bit count from input %0d",
							port, pkt_src[id]), pkt_payload[id].size(), got.size());
					// each bit leaves two cycles after its accept edge
					late = 1'b0;
					for (int k = 0; k < pkt_payload[id].size(); k++)
					begin
						acc = -1;
						if (accept_q[pkt_src[id]].size() > 0)
							acc = accept_q[pkt_src[id]].pop_front();
						if (k < got_cyc.size() && !late && got_cyc[k] != acc + 2)
						begin
							late = 1'b1;
							report_mismatch($sformatf("valido_n[%0d] cycle of bit %0d",
								port, k), acc + 2, got_cyc[k]);
						end
					end
				end
			end
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_TIME);
		$display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
		$display("errors: %0d, frames checked: %0d", errors, frames_checked);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
design/router_pkg.sv
design/header_capture.sv
design/switch_arbiter.sv
design/crossbar.sv
design/router_top.sv
+incdir+include
tests/router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the router testbench with Verilator, run it and check the log
verilator --binary --timing --assert -f tb.f --top-module router_tb -o router_sim \
	&& ./obj_dir/router_sim > sim.log 2>&1 \
	|| { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log \
	&& { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
